// ==== logic/isaPkg.sv ====
`default_nettype none

package isaPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regIndex_t;
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Byte size of one instruction
    localparam word_t wordBytes = 32'd4;

    // Primary opcodes
    localparam opcode_t opSpecial = 6'h00;
    localparam opcode_t opBeq = 6'h04;
    localparam opcode_t opBne = 6'h05;
    localparam opcode_t opAddiu = 6'h09;
    localparam opcode_t opOri = 6'h0d;
    localparam opcode_t opLui = 6'h0f;
    localparam opcode_t opLb = 6'h20;
    localparam opcode_t opLw = 6'h23;
    localparam opcode_t opLbu = 6'h24;
    localparam opcode_t opSb = 6'h28;
    localparam opcode_t opSw = 6'h2b;

    // Function codes under opSpecial
    localparam funct_t fnAddu = 6'h21;
    localparam funct_t fnSubu = 6'h23;
    localparam funct_t fnAnd = 6'h24;
    localparam funct_t fnOr = 6'h25;
    localparam funct_t fnXor = 6'h26;
    localparam funct_t fnSlt = 6'h2a;

endpackage

`default_nettype wire

// ==== logic/pipePkg.sv ====
`default_nettype none

package pipePkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluLui
    } aluOp_t;

    typedef enum logic [1:0] {
        wbNone = 2'd0,
        wbAlu = 2'd1,
        wbMem = 2'd2
    } wbSource_t;

    // Also the encoding seen on the data memory size lines
    typedef enum logic [1:0] {
        memNone = 2'd0,
        memByte = 2'd1,
        memWord = 2'd2
    } memWidth_t;

    typedef enum logic [1:0] {
        cmpNone,
        cmpEqual,
        cmpNotEqual
    } cmpOp_t;

    // Control fields of an instruction that does nothing
    localparam aluOp_t nopAluOp = aluAdd;
    localparam wbSource_t nopWbSource = wbNone;
    localparam memWidth_t nopMemWidth = memNone;
    localparam cmpOp_t nopCmpOp = cmpNone;

endpackage

`default_nettype wire

// ==== logic/fetchUnit.sv ====
`default_nettype none

module fetchUnit import isaPkg::*; #(
    parameter word_t resetVector = '0
) (
    input wire clk,
    input wire reset,
    input wire stall,
    input wire redirect,
    input wire word_t redirectAddr,
    output word_t instAddr,
    output logic instRead,
    input wire word_t instData,
    input wire instValid,
    output word_t fetchedInst,
    output word_t fetchedPc,
    output logic fetchedValid
);

    word_t pc;
    logic started;
    logic holdValid;
    word_t holdInst;
    word_t holdPc;
    logic pendValid;
    word_t pendAddr;
    logic fetchDone;
    logic haveRedirect;
    word_t target;

    // No request while a buffered word waits to be taken
    assign instAddr = pc;
    assign instRead = started && !holdValid;
    assign fetchDone = instRead && instValid;

    assign haveRedirect = redirect || pendValid;
    assign target = redirect ? redirectAddr : pendAddr;

    assign fetchedValid = holdValid || fetchDone;
    assign fetchedInst = holdValid ? holdInst : instData;
    assign fetchedPc = holdValid ? holdPc : pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
            started <= 1'b0;
            holdValid <= 1'b0;
            pendValid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (fetchDone) begin
                pc <= haveRedirect ? target : pc + wordBytes;
                pendValid <= 1'b0;
            end else if (holdValid && haveRedirect) begin
                // Nothing in flight, jump right away
                pc <= target;
                pendValid <= 1'b0;
            end else if (redirect) begin
                pendValid <= 1'b1;
            end
            if (fetchDone && stall) begin
                holdValid <= 1'b1;
            end else if (!stall) begin
                holdValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone && stall) begin
            holdInst <= instData;
            holdPc <= pc;
        end
        if (redirect) begin
            pendAddr <= redirectAddr;
        end
    end

endmodule

`default_nettype wire

// ==== logic/instructionDecoder.sv ====
`default_nettype none

module instructionDecoder import isaPkg::*, pipePkg::*; (
    input wire word_t inst,
    output regIndex_t readReg1,
    output regIndex_t readReg2,
    output regIndex_t destReg,
    output aluOp_t aluOp,
    output logic useImmediate,
    output word_t immediate,
    output wbSource_t wbSource,
    output memWidth_t memWidth,
    output logic memStore,
    output logic loadSigned,
    output cmpOp_t cmpOp
);

    opcode_t opcode;
    funct_t funct;
    regIndex_t rs;
    regIndex_t rt;
    regIndex_t rd;
    logic [15:0] imm16;

    assign opcode = inst[31:26];
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];
    assign funct = inst[5:0];
    assign imm16 = inst[15:0];

    // Unused read ports stay at register 0 so they never hazard
    always_comb begin
        readReg1 = '0;
        readReg2 = '0;
        destReg = '0;
        aluOp = nopAluOp;
        useImmediate = 1'b0;
        immediate = {{16{imm16[15]}}, imm16};
        wbSource = nopWbSource;
        memWidth = nopMemWidth;
        memStore = 1'b0;
        loadSigned = 1'b0;
        cmpOp = nopCmpOp;
        case (opcode)
            opSpecial: begin
                if (funct inside {fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt}) begin
                    readReg1 = rs;
                    readReg2 = rt;
                    destReg = rd;
                    wbSource = wbAlu;
                end
                case (funct)
                    fnSubu: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr: aluOp = aluOr;
                    fnXor: aluOp = aluXor;
                    fnSlt: aluOp = aluSlt;
                    default: aluOp = aluAdd;
                endcase
            end
            opAddiu, opOri, opLui: begin
                readReg1 = (opcode == opLui) ? 5'd0 : rs;
                destReg = rt;
                useImmediate = 1'b1;
                wbSource = wbAlu;
                if (opcode == opOri) begin
                    aluOp = aluOr;
                    immediate = {16'h0, imm16};
                end else if (opcode == opLui) begin
                    aluOp = aluLui;
                    immediate = {imm16, 16'h0};
                end
            end
            opLw, opLb, opLbu: begin
                readReg1 = rs;
                destReg = rt;
                useImmediate = 1'b1;
                wbSource = wbMem;
                memWidth = (opcode == opLw) ? memWord : memByte;
                loadSigned = (opcode == opLb);
            end
            opSw, opSb: begin
                readReg1 = rs;
                readReg2 = rt;
                useImmediate = 1'b1;
                memStore = 1'b1;
                memWidth = (opcode == opSw) ? memWord : memByte;
            end
            opBeq, opBne: begin
                readReg1 = rs;
                readReg2 = rt;
                cmpOp = (opcode == opBeq) ? cmpEqual : cmpNotEqual;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/registerFile.sv ====
`default_nettype none

module registerFile import isaPkg::*; (
    input wire clk,
    input wire reset,
    input wire regIndex_t readAddr1,
    input wire regIndex_t readAddr2,
    output word_t readData1,
    output word_t readData2,
    input wire regIndex_t writeAddr,
    input wire word_t writeData
);

    word_t regs [32];

    // A write address of zero means no write
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write is visible to readers
    assign readData1 = (readAddr1 == '0) ? '0 :
                       (readAddr1 == writeAddr) ? writeData : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 :
                       (readAddr2 == writeAddr) ? writeData : regs[readAddr2];

endmodule

`default_nettype wire

// ==== logic/forwardSelect.sv ====
`default_nettype none

module forwardSelect import isaPkg::*; (
    input wire regIndex_t request,
    input wire word_t original,
    input wire needed,
    input wire eReady,
    input wire mReady,
    input wire regIndex_t eDest,
    input wire regIndex_t mDest,
    input wire regIndex_t wDest,
    input wire word_t eValue,
    input wire word_t mValue,
    input wire word_t wValue,
    output word_t value,
    output logic notReady
);

    // Youngest producer first
    always_comb begin
        value = original;
        notReady = 1'b0;
        if (request != '0) begin
            if (request == eDest) begin
                value = eValue;
                notReady = needed && !eReady;
            end else if (request == mDest) begin
                value = mValue;
                notReady = needed && !mReady;
            end else if (request == wDest) begin
                value = wValue;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/arithmeticUnit.sv ====
`default_nettype none

module arithmeticUnit import isaPkg::*, pipePkg::*; (
    input wire aluOp_t aluOp,
    input wire word_t a,
    input wire word_t b,
    output word_t result,
    input wire word_t cmpA,
    input wire word_t cmpB,
    input wire cmpOp_t cmpOp,
    output logic taken
);

    always_comb begin
        case (aluOp)
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr: result = a | b;
            aluXor: result = a ^ b;
            aluSlt: result = word_t'($signed(a) < $signed(b));
            aluLui: result = b;
            default: result = a + b;
        endcase
    end

    // Branch decision, used one stage earlier than the ALU
    always_comb begin
        case (cmpOp)
            cmpEqual: taken = (cmpA == cmpB);
            cmpNotEqual: taken = (cmpA != cmpB);
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/loadStoreUnit.sv ====
`default_nettype none

module loadStoreUnit import isaPkg::*, pipePkg::*; (
    input wire clk,
    input wire reset,
    input wire memWidth_t memWidth,
    input wire memStore,
    input wire loadSigned,
    input wire word_t address,
    input wire word_t storeValue,
    output word_t dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output word_t dataWdata,
    output memWidth_t dataSize,
    input wire word_t dataRdata,
    input wire dataValid,
    output word_t loadValue,
    output logic waiting
);

    logic active;
    logic done;
    logic [4:0] laneShift;
    logic [7:0] loadByte;
    word_t extended;

    assign active = (memWidth != memNone);
    assign laneShift = {address[1:0], 3'b000};

    // Request stays up until the access has completed once
    assign waiting = active && !done;
    assign dataAddr = address;
    assign dataRead = waiting && !memStore;
    assign dataWrite = waiting && memStore;
    assign dataSize = memWidth;
    assign dataWdata = (memWidth == memByte) ? ({24'h0, storeValue[7:0]} << laneShift)
                                             : storeValue;

    assign loadByte = dataRdata[laneShift +: 8];

    always_comb begin
        if (memWidth == memByte) begin
            extended = loadSigned ? {{24{loadByte[7]}}, loadByte} : {24'h0, loadByte};
        end else begin
            extended = dataRdata;
        end
    end

    // Done lasts one cycle, the stage moves on right after
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= waiting && dataValid;
        end
    end

    always_ff @(posedge clk) begin
        if (waiting && dataValid) begin
            loadValue <= extended;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpuCore.sv ====
`default_nettype none

module cpuCore import isaPkg::*, pipePkg::*; #(
    parameter word_t resetVector = '0
) (
    input wire clk,
    input wire reset,
    output word_t instAddr,
    output logic instRead,
    input wire word_t instData,
    input wire instValid,
    output word_t dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output word_t dataWdata,
    output memWidth_t dataSize,
    input wire word_t dataRdata,
    input wire dataValid,
    output word_t debugPc,
    output logic [3:0] debugWen,
    output regIndex_t debugWnum,
    output word_t debugWdata
);

    logic stallFront;
    logic redirect;
    word_t redirectAddr;
    word_t fetchedInst, fetchedPc;
    logic fetchedValid;

    // Decode stage
    logic dValid;
    word_t dPc, dInst;
    regIndex_t dReadReg1, dReadReg2, dDestReg;
    aluOp_t dAluOp;
    logic dUseImm, dMemStore, dLoadSigned, dTaken;
    word_t dImm, rfData1, rfData2, dOperand1, dOperand2;
    wbSource_t dWbSource;
    memWidth_t dMemWidth;
    cmpOp_t dCmpOp;
    logic notReady1, notReady2, dHazard;

    // Execute stage
    logic eValid, eUseImm, eMemStore, eLoadSigned;
    word_t ePc, eImm, eA, eB, aluB, eResult;
    regIndex_t eDest, eFwdDest;
    aluOp_t eAluOp;
    wbSource_t eWbSource;
    memWidth_t eMemWidth;

    // Memory stage
    logic mValid, mMemStore, mLoadSigned, mWait, mReady;
    word_t mPc, mAluResult, mStoreValue, mLoadValue, mResult;
    regIndex_t mDest, mFwdDest;
    wbSource_t mWbSource;
    memWidth_t mMemWidth, mAccess;

    // Writeback stage
    logic wValid;
    word_t wPc, wResult;
    regIndex_t wDest, wWriteAddr;

    assign dHazard = notReady1 || notReady2;
    assign stallFront = mWait || dHazard;
    assign redirect = dValid && dTaken && !stallFront;
    assign redirectAddr = dPc + wordBytes + {dImm[29:0], 2'b00};

    fetchUnit #(.resetVector(resetVector)) fetch_i (
        .clk(clk), .reset(reset), .stall(stallFront),
        .redirect(redirect), .redirectAddr(redirectAddr),
        .instAddr(instAddr), .instRead(instRead), .instData(instData), .instValid(instValid),
        .fetchedInst(fetchedInst), .fetchedPc(fetchedPc), .fetchedValid(fetchedValid)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            dValid <= 1'b0;
        end else if (!stallFront) begin
            dValid <= fetchedValid;
            dPc <= fetchedPc;
            dInst <= fetchedInst;
        end
    end

    instructionDecoder decoder_i (
        .inst(dInst), .readReg1(dReadReg1), .readReg2(dReadReg2), .destReg(dDestReg),
        .aluOp(dAluOp), .useImmediate(dUseImm), .immediate(dImm), .wbSource(dWbSource),
        .memWidth(dMemWidth), .memStore(dMemStore), .loadSigned(dLoadSigned), .cmpOp(dCmpOp)
    );

    registerFile regFile_i (
        .clk(clk), .reset(reset),
        .readAddr1(dReadReg1), .readAddr2(dReadReg2),
        .readData1(rfData1), .readData2(rfData2),
        .writeAddr(wWriteAddr), .writeData(wResult)
    );

    // Execute results come from the ALU one cycle later, never ready here
    forwardSelect forward1_i (
        .request(dReadReg1), .original(rfData1), .needed(dValid),
        .eReady(1'b0), .mReady(mReady),
        .eDest(eFwdDest), .mDest(mFwdDest), .wDest(wWriteAddr),
        .eValue(eResult), .mValue(mResult), .wValue(wResult),
        .value(dOperand1), .notReady(notReady1)
    );

    forwardSelect forward2_i (
        .request(dReadReg2), .original(rfData2), .needed(dValid),
        .eReady(1'b0), .mReady(mReady),
        .eDest(eFwdDest), .mDest(mFwdDest), .wDest(wWriteAddr),
        .eValue(eResult), .mValue(mResult), .wValue(wResult),
        .value(dOperand2), .notReady(notReady2)
    );

    // A hazard in decode leaves a bubble in execute
    always_ff @(posedge clk) begin
        if (reset) begin
            eValid <= 1'b0;
        end else if (!mWait) begin
            eValid <= dValid && !dHazard;
            ePc <= dPc;
            eDest <= dDestReg;
            eAluOp <= dAluOp;
            eUseImm <= dUseImm;
            eImm <= dImm;
            eA <= dOperand1;
            eB <= dOperand2;
            eWbSource <= dWbSource;
            eMemWidth <= dMemWidth;
            eMemStore <= dMemStore;
            eLoadSigned <= dLoadSigned;
        end
    end

    assign aluB = eUseImm ? eImm : eB;
    assign eFwdDest = eValid ? eDest : '0;

    arithmeticUnit alu_i (
        .aluOp(eAluOp), .a(eA), .b(aluB), .result(eResult),
        .cmpA(dOperand1), .cmpB(dOperand2), .cmpOp(dCmpOp), .taken(dTaken)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            mValid <= 1'b0;
        end else if (!mWait) begin
            mValid <= eValid;
            mPc <= ePc;
            mDest <= eDest;
            mWbSource <= eWbSource;
            mMemWidth <= eMemWidth;
            mMemStore <= eMemStore;
            mLoadSigned <= eLoadSigned;
            mAluResult <= eResult;
            mStoreValue <= eB;
        end
    end

    assign mAccess = mValid ? mMemWidth : nopMemWidth;

    loadStoreUnit lsu_i (
        .clk(clk), .reset(reset),
        .memWidth(mAccess), .memStore(mMemStore), .loadSigned(mLoadSigned),
        .address(mAluResult), .storeValue(mStoreValue),
        .dataAddr(dataAddr), .dataRead(dataRead), .dataWrite(dataWrite),
        .dataWdata(dataWdata), .dataSize(dataSize),
        .dataRdata(dataRdata), .dataValid(dataValid),
        .loadValue(mLoadValue), .waiting(mWait)
    );

    assign mResult = (mWbSource == wbMem) ? mLoadValue : mAluResult;
    assign mReady = (mWbSource != wbMem) || !mWait;
    assign mFwdDest = mValid ? mDest : '0;

    // Writeback sees a bubble while the memory stage waits
    always_ff @(posedge clk) begin
        if (reset) begin
            wValid <= 1'b0;
        end else begin
            wValid <= mValid && !mWait;
            wPc <= mPc;
            wDest <= mDest;
            wResult <= mResult;
        end
    end

    assign wWriteAddr = wValid ? wDest : '0;

    assign debugPc = wPc;
    assign debugWen = (wWriteAddr != '0) ? 4'hf : 4'h0;
    assign debugWnum = wWriteAddr;
    assign debugWdata = wResult;

endmodule

`default_nettype wire

// ==== testbench/memoryModel.sv ====
`default_nettype none

module memoryModel import isaPkg::*, pipePkg::*; #(
    parameter int instWords = 1024,
    parameter logic [31:0] seedInit = 32'h1
) (
    input wire clk,
    input wire word_t instAddr,
    input wire instRead,
    output word_t instData,
    output logic instValid,
    input wire word_t dataAddr,
    input wire dataRead,
    input wire dataWrite,
    input wire word_t dataWdata,
    input wire memWidth_t dataSize,
    output word_t dataRdata,
    output logic dataValid
);

    localparam int dataWords = 64;

    // Contents are written by the testbench before reset ends
    word_t instMem [instWords];
    word_t dataMem [dataWords];

    integer seed;
    int instCount;
    int dataCount;
    logic instDone;
    logic dataDone;

    initial begin
        seed = seedInit;
        instData = '0;
        instValid = 1'b0;
        dataRdata = '0;
        dataValid = 1'b0;
        instCount = 0;
        dataCount = 0;
    end

    // Looks at the core a little after the edge, when its outputs have settled
    always @(posedge clk) begin
        #1;
        instDone = instValid;
        instValid = 1'b0;
        if (instDone) begin
            instCount = {$random(seed)} % 4;
        end
        if (instRead) begin
            if (instCount == 0) begin
                instValid = 1'b1;
                if (instAddr[31:2] < instWords) begin
                    instData = instMem[instAddr[31:2]];
                end else begin
                    instData = '0;
                end
            end else begin
                instCount = instCount - 1;
            end
        end

        dataDone = dataValid;
        dataValid = 1'b0;
        if (dataDone) begin
            dataCount = {$random(seed)} % 4;
        end
        if (dataRead || dataWrite) begin
            if (dataCount == 0) begin
                dataValid = 1'b1;
                if (dataWrite && dataSize == memByte) begin
                    dataMem[dataAddr[7:2]][8 * dataAddr[1:0] +: 8] =
                        dataWdata[8 * dataAddr[1:0] +: 8];
                end else if (dataWrite) begin
                    dataMem[dataAddr[7:2]] = dataWdata;
                end
                dataRdata = dataMem[dataAddr[7:2]];
            end else begin
                dataCount = dataCount - 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/cpuTb.sv ====
`default_nettype none

module cpuTb
    import isaPkg::*, pipePkg::*;
();

    localparam int progLength = 400;
    localparam int instWords = 1024;
    localparam int dataBytes = 256;
    localparam int drainCycles = 30;
    localparam logic [31:0] seedValue = 32'hfff5418e;
    // Up to a few wait cycles on each port per instruction, plus margin
    localparam int cycleLimit = (progLength + 50) * 12;

    logic clk = 1'b0;
    logic reset;
    word_t instAddr;
    logic instRead;
    word_t instData;
    logic instValid;
    word_t dataAddr;
    logic dataRead;
    logic dataWrite;
    word_t dataWdata;
    memWidth_t dataSize;
    word_t dataRdata;
    logic dataValid;
    word_t debugPc;
    logic [3:0] debugWen;
    regIndex_t debugWnum;
    word_t debugWdata;

    integer seed = seedValue;

    word_t progMem [progLength];
    word_t refRegs [32];
    logic [7:0] refMem [dataBytes];
    word_t refPc;
    word_t refNextPc;

    word_t expPc [$];
    regIndex_t expNum [$];
    word_t expValue [$];
    int expectedTotal = 0;
    int writesSeen = 0;
    int errorCount = 0;
    int extraWrites = 0;
    int cycleCount = 0;

    cpuCore dut_i (
        .clk(clk), .reset(reset),
        .instAddr(instAddr), .instRead(instRead), .instData(instData), .instValid(instValid),
        .dataAddr(dataAddr), .dataRead(dataRead), .dataWrite(dataWrite),
        .dataWdata(dataWdata), .dataSize(dataSize),
        .dataRdata(dataRdata), .dataValid(dataValid),
        .debugPc(debugPc), .debugWen(debugWen), .debugWnum(debugWnum), .debugWdata(debugWdata)
    );

    memoryModel #(.instWords(instWords), .seedInit(seedValue)) memory_i (
        .clk(clk),
        .instAddr(instAddr), .instRead(instRead), .instData(instData), .instValid(instValid),
        .dataAddr(dataAddr), .dataRead(dataRead), .dataWrite(dataWrite),
        .dataWdata(dataWdata), .dataSize(dataSize),
        .dataRdata(dataRdata), .dataValid(dataValid)
    );

    always #4 clk = ~clk;

    function automatic word_t encodeR(funct_t fn, regIndex_t rs, regIndex_t rt, regIndex_t rd);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encodeI(opcode_t op, regIndex_t rs, regIndex_t rt,
                                      logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Few registers, so dependencies and r0 targets show up often
    function automatic regIndex_t pickReg();
        return regIndex_t'({$random(seed)} % 8);
    endfunction

    task automatic buildProgram();
        int kind;
        logic [15:0] imm;
        logic [15:0] offset;
        logic [15:0] skip;
        bit lastBranch;
        lastBranch = 1'b0;
        for (int i = 0; i < progLength; i++) begin
            kind = {$random(seed)} % 16;
            // Never a branch in a delay slot
            if (lastBranch && kind >= 14) begin
                kind = 6;
            end
            imm = 16'($random(seed));
            offset = 16'({$random(seed)} % dataBytes);
            skip = 16'({$random(seed)} % 4 + 1);
            case (kind)
                0: progMem[i] = encodeR(fnAddu, pickReg(), pickReg(), pickReg());
                1: progMem[i] = encodeR(fnSubu, pickReg(), pickReg(), pickReg());
                2: progMem[i] = encodeR(fnAnd, pickReg(), pickReg(), pickReg());
                3: progMem[i] = encodeR(fnOr, pickReg(), pickReg(), pickReg());
                4: progMem[i] = encodeR(fnXor, pickReg(), pickReg(), pickReg());
                5: progMem[i] = encodeR(fnSlt, pickReg(), pickReg(), pickReg());
                6: progMem[i] = encodeI(opAddiu, pickReg(), pickReg(), imm);
                7: progMem[i] = encodeI(opOri, pickReg(), pickReg(), imm);
                8: progMem[i] = encodeI(opLui, 5'd0, pickReg(), imm);
                9: progMem[i] = encodeI(opLw, 5'd0, pickReg(), offset & 16'hfffc);
                10: progMem[i] = encodeI(opLb, 5'd0, pickReg(), offset);
                11: progMem[i] = encodeI(opLbu, 5'd0, pickReg(), offset);
                12: progMem[i] = encodeI(opSw, 5'd0, pickReg(), offset & 16'hfffc);
                13: progMem[i] = encodeI(opSb, 5'd0, pickReg(), offset);
                14: progMem[i] = encodeI(opBeq, pickReg(), pickReg(), skip);
                default: progMem[i] = encodeI(opBne, pickReg(), pickReg(), skip);
            endcase
            lastBranch = (kind >= 14);
        end
    endtask

    task automatic loadMemories();
        for (int i = 0; i < instWords; i++) begin
            if (i < progLength) begin
                memory_i.instMem[i] = progMem[i];
            end else begin
                memory_i.instMem[i] = '0;
            end
        end
        for (int a = 0; a < dataBytes; a++) begin
            refMem[a] = 8'(a * 29) ^ 8'hc3;
        end
        for (int w = 0; w < dataBytes / 4; w++) begin
            memory_i.dataMem[w] = {refMem[4*w+3], refMem[4*w+2], refMem[4*w+1], refMem[4*w]};
        end
        for (int r = 0; r < 32; r++) begin
            refRegs[r] = '0;
        end
        refPc = '0;
        refNextPc = wordBytes;
    endtask

    // Runs the program until the next write to a nonzero register
    function automatic bit nextWrite(output word_t wrPc, output regIndex_t wrNum,
                                     output word_t wrValue);
        word_t inst;
        word_t curPc;
        word_t a;
        word_t b;
        word_t imm;
        word_t result;
        logic [7:0] addr;
        regIndex_t dest;
        bit taken;
        bit found;
        found = 1'b0;
        wrPc = '0;
        wrNum = '0;
        wrValue = '0;
        while (!found && refPc < progLength * wordBytes) begin
            curPc = refPc;
            inst = progMem[curPc[31:2]];
            a = refRegs[inst[25:21]];
            b = refRegs[inst[20:16]];
            imm = {{16{inst[15]}}, inst[15:0]};
            addr = 8'(a + imm);
            dest = '0;
            result = '0;
            taken = 1'b0;
            case (opcode_t'(inst[31:26]))
                opSpecial: begin
                    dest = inst[15:11];
                    case (funct_t'(inst[5:0]))
                        fnAddu: result = a + b;
                        fnSubu: result = a - b;
                        fnAnd: result = a & b;
                        fnOr: result = a | b;
                        fnXor: result = a ^ b;
                        fnSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: dest = '0;
                    endcase
                end
                opAddiu: begin
                    dest = inst[20:16];
                    result = a + imm;
                end
                opOri: begin
                    dest = inst[20:16];
                    result = a | {16'h0, inst[15:0]};
                end
                opLui: begin
                    dest = inst[20:16];
                    result = {inst[15:0], 16'h0};
                end
                opLw: begin
                    dest = inst[20:16];
                    result = {refMem[addr + 8'd3], refMem[addr + 8'd2],
                              refMem[addr + 8'd1], refMem[addr]};
                end
                opLb: begin
                    dest = inst[20:16];
                    result = {{24{refMem[addr][7]}}, refMem[addr]};
                end
                opLbu: begin
                    dest = inst[20:16];
                    result = {24'h0, refMem[addr]};
                end
                opSw: begin
                    refMem[addr] = b[7:0];
                    refMem[addr + 8'd1] = b[15:8];
                    refMem[addr + 8'd2] = b[23:16];
                    refMem[addr + 8'd3] = b[31:24];
                end
                opSb: refMem[addr] = b[7:0];
                opBeq: taken = (a == b);
                opBne: taken = (a != b);
                default: begin
                end
            endcase
            if (dest != '0) begin
                refRegs[dest] = result;
                found = 1'b1;
                wrPc = curPc;
                wrNum = dest;
                wrValue = result;
            end
            // Delay slot runs before the target
            refPc = refNextPc;
            refNextPc = taken ? curPc + wordBytes + {imm[29:0], 2'b00} : refNextPc + wordBytes;
        end
        return found;
    endfunction

    task automatic buildExpected();
        word_t pc;
        regIndex_t num;
        word_t value;
        while (nextWrite(pc, num, value)) begin
            expPc.push_back(pc);
            expNum.push_back(num);
            expValue.push_back(value);
        end
        expectedTotal = expPc.size();
    endtask

    task automatic checkWord(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            errorCount++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic checkRegIndex(input string what, input regIndex_t got,
                                 input regIndex_t expected);
        if (got !== expected) begin
            errorCount++;
            $display("ERROR at %0t: %s is r%0d, expected r%0d", $time, what, got, expected);
        end
    endtask

    // Writeback outputs come from registers, stable at the falling edge
    always @(negedge clk) begin
        if (!reset && debugWen != 4'h0) begin
            if (debugWen != 4'hf) begin
                errorCount++;
                $display("ERROR at %0t: debugWen is %h, not all ones", $time, debugWen);
            end
            if (expPc.size() == 0) begin
                errorCount++;
                extraWrites++;
                $display("Unexpected write to r%0d at time %0t, no more writes were due",
                         debugWnum, $time);
            end else begin
                checkWord("write pc", debugPc, expPc.pop_front());
                checkRegIndex("write register", debugWnum, expNum.pop_front());
                checkWord("write value", debugWdata, expValue.pop_front());
                writesSeen++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles with %0d of %0d writes seen",
                     cycleCount, writesSeen, expectedTotal);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        buildProgram();
        loadMemories();
        buildExpected();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        while (writesSeen < expectedTotal) begin
            @(posedge clk);
        end
        // Catch writes that come after the last expected one
        repeat (drainCycles) @(posedge clk);
        $display("Writes checked %0d of %0d, unexpected writes %0d, errors %0d",
                 writesSeen, expectedTotal, extraWrites, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/isaPkg.sv
logic/pipePkg.sv
logic/fetchUnit.sv
logic/instructionDecoder.sv
logic/registerFile.sv
logic/forwardSelect.sv
logic/arithmeticUnit.sv
logic/loadStoreUnit.sv
logic/cpuCore.sv
testbench/memoryModel.sv
testbench/cpuTb.sv
